//--- cpuPkg.sv
package cpuPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'hBFC0_0000;  // boot rom base

    // primary opcode field, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // function field of SPECIAL, instr[5:0]
    localparam logic [5:0] FUNCT_JR   = 6'h08;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_SLT  = 6'h2A;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } aluOpT;

    // operand source for decode, youngest producer wins
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwdSelT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;  // all zero is sll $0 and retires as a no-op
    } fetchToDecT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       opA;
        logic [XLEN-1:0]       opB;        // immediate or forwarded rt
        logic [XLEN-1:0]       storeData;  // rt value for sw
        aluOpT                 aluOp;
        logic [REG_ADDR_W-1:0] dst;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
    } decToExT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       aluResult;  // also the data address
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] dst;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
    } exToMemT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] dst;
        logic                  regWrite;
    } memToWbT;

endpackage

//--- stageReg.sv
`timescale 1ns/100ps

// pipeline register between two stages
// bubble beats stall, so a held stage can still be emptied
module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    arstN_i,
    input  logic    stall_i,   // keep current contents
    input  logic    bubble_i,  // load an all-zero payload
    input  payloadT d_i,
    output payloadT q_o
);

    payloadT q;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            q <= '0;
        end else if (bubble_i) begin
            q <= '0;  // zero payload means no write, no memory access
        end else if (!stall_i) begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

//--- regFile.sv
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  arstN_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] wAddr_i,
    input  logic [XLEN-1:0]       wData_i,
    input  logic [REG_ADDR_W-1:0] rsAddr_i,
    input  logic [REG_ADDR_W-1:0] rtAddr_i,
    output logic [XLEN-1:0]       rsData_o,
    output logic [XLEN-1:0]       rtData_o
);

    logic [XLEN-1:0] regs [1:31];  // $0 has no storage

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wAddr_i != '0)) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // reads are combinational, same-cycle write comes in via the wb forward
    assign rsData_o = (rsAddr_i == '0) ? '0 : regs[rsAddr_i];
    assign rtData_o = (rtAddr_i == '0) ? '0 : regs[rtAddr_i];

    // decode drops regWrite for dst zero, so nothing downstream should try it
    noWriteToZero: assert property (
        @(posedge clk) disable iff (!arstN_i)
        we_i |-> (wAddr_i != '0)
    ) else $error("regFile: write pulse to register zero");

endmodule

//--- decodeUnit.sv
`timescale 1ns/100ps

module decodeUnit import cpuPkg::*; (
    input  logic [XLEN-1:0]       instr_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rsData_i,
    input  logic [XLEN-1:0]       rtData_i,
    input  fwdSelT                fwdRs_i,
    input  fwdSelT                fwdRt_i,
    input  logic [XLEN-1:0]       exFwd_i,
    input  logic [XLEN-1:0]       memFwd_i,
    input  logic [XLEN-1:0]       wbFwd_i,
    output logic [REG_ADDR_W-1:0] rsAddr_o,
    output logic [REG_ADDR_W-1:0] rtAddr_o,
    output decToExT               exPayload_o,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirectPc_o
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rdAddr;
    logic [XLEN-1:0]       immSext;
    logic [XLEN-1:0]       immZext;
    logic [XLEN-1:0]       pcPlus4;
    logic [XLEN-1:0]       rsVal;
    logic [XLEN-1:0]       rtVal;
    logic [REG_ADDR_W-1:0] dst;
    logic                  regWrite;

    assign opcode   = instr_i[31:26];
    assign rsAddr_o = instr_i[25:21];
    assign rtAddr_o = instr_i[20:16];
    assign rdAddr   = instr_i[15:11];
    assign funct    = instr_i[5:0];
    assign immSext  = {{16{instr_i[15]}}, instr_i[15:0]};
    assign immZext  = {16'h0000, instr_i[15:0]};
    assign pcPlus4  = pc_i + 32'd4;

    function automatic logic [XLEN-1:0] pickOperand(input fwdSelT sel,
                                                    input logic [XLEN-1:0] regVal,
                                                    input logic [XLEN-1:0] exVal,
                                                    input logic [XLEN-1:0] memVal,
                                                    input logic [XLEN-1:0] wbVal);
        case (sel)
            FWD_EX:  return exVal;
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign rsVal = pickOperand(fwdRs_i, rsData_i, exFwd_i, memFwd_i, wbFwd_i);
    assign rtVal = pickOperand(fwdRt_i, rtData_i, exFwd_i, memFwd_i, wbFwd_i);

    always_comb begin
        exPayload_o           = '0;
        exPayload_o.pc        = pc_i;
        exPayload_o.opA       = rsVal;
        exPayload_o.opB       = rtVal;
        exPayload_o.storeData = rtVal;
        exPayload_o.aluOp     = ALU_ADD;
        regWrite              = 1'b0;
        dst                   = '0;
        redirect_o            = 1'b0;
        redirectPc_o          = pcPlus4 + {immSext[XLEN-3:0], 2'b00};  // branch target
        case (opcode)
            OP_SPECIAL: begin
                regWrite = 1'b1;
                dst      = rdAddr;
                case (funct)
                    FUNCT_ADDU: exPayload_o.aluOp = ALU_ADD;
                    FUNCT_SUBU: exPayload_o.aluOp = ALU_SUB;
                    FUNCT_AND:  exPayload_o.aluOp = ALU_AND;
                    FUNCT_OR:   exPayload_o.aluOp = ALU_OR;
                    FUNCT_XOR:  exPayload_o.aluOp = ALU_XOR;
                    FUNCT_SLT:  exPayload_o.aluOp = ALU_SLT;
                    FUNCT_JR: begin
                        regWrite     = 1'b0;
                        redirect_o   = 1'b1;
                        redirectPc_o = rsVal;
                    end
                    default: regWrite = 1'b0;  // sll $0 and friends retire silently
                endcase
            end
            OP_J: begin
                redirect_o   = 1'b1;
                redirectPc_o = {pcPlus4[31:28], instr_i[25:0], 2'b00};
            end
            OP_BEQ: redirect_o = (rsVal == rtVal);
            OP_BNE: redirect_o = (rsVal != rtVal);
            OP_ADDIU: begin
                regWrite        = 1'b1;
                dst             = rtAddr_o;
                exPayload_o.opB = immSext;
            end
            OP_ANDI, OP_ORI, OP_LUI: begin
                regWrite          = 1'b1;
                dst               = rtAddr_o;
                exPayload_o.opB   = immZext;
                exPayload_o.aluOp = (opcode == OP_ANDI) ? ALU_AND :
                                    (opcode == OP_ORI)  ? ALU_OR  : ALU_LUI;
            end
            OP_LW: begin
                regWrite            = 1'b1;
                dst                 = rtAddr_o;
                exPayload_o.opB     = immSext;
                exPayload_o.memRead = 1'b1;
            end
            OP_SW: begin
                exPayload_o.opB      = immSext;
                exPayload_o.memWrite = 1'b1;
            end
            default: ;  // unknown opcode does nothing
        endcase
        exPayload_o.dst      = dst;
        exPayload_o.regWrite = regWrite && (dst != '0);
    end

endmodule

//--- hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit import cpuPkg::*; (
    input  logic [REG_ADDR_W-1:0] rsAddr_i,
    input  logic [REG_ADDR_W-1:0] rtAddr_i,
    input  logic [REG_ADDR_W-1:0] exDst_i,
    input  logic                  exRegWrite_i,
    input  logic                  exMemRead_i,
    input  logic [REG_ADDR_W-1:0] memDst_i,
    input  logic                  memRegWrite_i,
    input  logic [REG_ADDR_W-1:0] wbDst_i,
    input  logic                  wbRegWrite_i,
    output fwdSelT                fwdRs_o,
    output fwdSelT                fwdRt_o,
    output logic                  stallD_o
);

    // a load in execute has no data yet, so it is never an EX source
    function automatic fwdSelT pickSource(input logic [REG_ADDR_W-1:0] src);
        if (src == '0) begin
            return FWD_REG;  // $0 reads zero from the file
        end else if (exRegWrite_i && !exMemRead_i && (exDst_i == src)) begin
            return FWD_EX;
        end else if (memRegWrite_i && (memDst_i == src)) begin
            return FWD_MEM;  // memory stage picks load data itself
        end else if (wbRegWrite_i && (wbDst_i == src)) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwdRs_o  = pickSource(rsAddr_i);
        fwdRt_o  = pickSource(rtAddr_i);
        stallD_o = exMemRead_i && exRegWrite_i &&
                   ((exDst_i == rsAddr_i) || (exDst_i == rtAddr_i));
    end

endmodule

//--- execUnit.sv
`timescale 1ns/100ps

module execUnit import cpuPkg::*; (
    input  decToExT in_i,
    output exToMemT out_o
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;

    assign a = in_i.opA;
    assign b = in_i.opB;

    always_comb begin
        case (in_i.aluOp)
            ALU_ADD: result = a + b;  // addu, addiu and lw/sw address
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // controls ride along untouched
    always_comb begin
        out_o           = '0;
        out_o.pc        = in_i.pc;
        out_o.aluResult = result;
        out_o.storeData = in_i.storeData;
        out_o.dst       = in_i.dst;
        out_o.regWrite  = in_i.regWrite;
        out_o.memRead   = in_i.memRead;
        out_o.memWrite  = in_i.memWrite;
    end

endmodule

//--- coreTop.sv
`timescale 1ns/100ps

module coreTop import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  arstN_i,
    // instruction side
    output logic [XLEN-1:0]       instAddr_o,
    output logic                  instEn_o,
    input  logic [XLEN-1:0]       instr_i,
    // data side
    output logic                  memEn_o,
    output logic                  memWe_o,
    output logic [XLEN-1:0]       memAddr_o,
    output logic [XLEN-1:0]       memWdata_o,
    input  logic [XLEN-1:0]       memRdata_i,
    // writeback debug port
    output logic [XLEN-1:0]       dbgWbPc_o,
    output logic                  dbgWbWen_o,
    output logic [REG_ADDR_W-1:0] dbgWbNum_o,
    output logic [XLEN-1:0]       dbgWbData_o
);

    logic [XLEN-1:0]       pcQ;
    logic                  stallD;
    logic                  redirect;
    logic [XLEN-1:0]       redirectPc;
    fetchToDecT            fetchIn, decQ;
    decToExT               decOut, exQ;
    exToMemT               exOut, memQ;
    memToWbT               wbIn, wbQ;
    logic [REG_ADDR_W-1:0] rsAddr, rtAddr;
    logic [XLEN-1:0]       rsData, rtData;
    fwdSelT                fwdRs, fwdRt;
    logic [XLEN-1:0]       memResult;

    // the slot after a branch is already in fetch, so the redirect lands one later
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcQ <= RESET_PC;
        end else if (!stallD) begin
            pcQ <= redirect ? redirectPc : pcQ + 32'd4;
        end
    end

    assign instAddr_o = pcQ;
    assign instEn_o   = arstN_i && !stallD;
    assign fetchIn    = '{pc: pcQ, instr: instr_i};

    stageReg #(.payloadT(fetchToDecT)) fetchReg_i (
        .clk, .arstN_i, .stall_i(stallD), .bubble_i(1'b0), .d_i(fetchIn), .q_o(decQ)
    );

    regFile rf_i (
        .clk, .arstN_i,
        .we_i(wbQ.regWrite), .wAddr_i(wbQ.dst), .wData_i(wbQ.result),
        .rsAddr_i(rsAddr), .rtAddr_i(rtAddr), .rsData_o(rsData), .rtData_o(rtData)
    );

    decodeUnit decode_i (
        .instr_i(decQ.instr), .pc_i(decQ.pc),
        .rsData_i(rsData), .rtData_i(rtData),
        .fwdRs_i(fwdRs), .fwdRt_i(fwdRt),
        .exFwd_i(exOut.aluResult), .memFwd_i(memResult), .wbFwd_i(wbQ.result),
        .rsAddr_o(rsAddr), .rtAddr_o(rtAddr),
        .exPayload_o(decOut), .redirect_o(redirect), .redirectPc_o(redirectPc)
    );

    hazardUnit hazard_i (
        .rsAddr_i(rsAddr), .rtAddr_i(rtAddr),
        .exDst_i(exQ.dst), .exRegWrite_i(exQ.regWrite), .exMemRead_i(exQ.memRead),
        .memDst_i(memQ.dst), .memRegWrite_i(memQ.regWrite),
        .wbDst_i(wbQ.dst), .wbRegWrite_i(wbQ.regWrite),
        .fwdRs_o(fwdRs), .fwdRt_o(fwdRt), .stallD_o(stallD)
    );

    stageReg #(.payloadT(decToExT)) exReg_i (
        .clk, .arstN_i, .stall_i(1'b0), .bubble_i(stallD), .d_i(decOut), .q_o(exQ)
    );

    execUnit exec_i (.in_i(exQ), .out_o(exOut));

    stageReg #(.payloadT(exToMemT)) memReg_i (
        .clk, .arstN_i, .stall_i(1'b0), .bubble_i(1'b0), .d_i(exOut), .q_o(memQ)
    );

    // one strobe per lw/sw, memory answers in the same cycle
    assign memEn_o    = memQ.memRead || memQ.memWrite;
    assign memWe_o    = memQ.memWrite;
    assign memAddr_o  = memQ.aluResult;
    assign memWdata_o = memQ.storeData;

    assign memResult = memQ.memRead ? memRdata_i : memQ.aluResult;
    assign wbIn      = '{pc: memQ.pc, result: memResult, dst: memQ.dst, regWrite: memQ.regWrite};

    stageReg #(.payloadT(memToWbT)) wbReg_i (
        .clk, .arstN_i, .stall_i(1'b0), .bubble_i(1'b0), .d_i(wbIn), .q_o(wbQ)
    );

    assign dbgWbPc_o   = wbQ.pc;
    assign dbgWbWen_o  = wbQ.regWrite;  // retire marker
    assign dbgWbNum_o  = wbQ.dst;
    assign dbgWbData_o = wbQ.result;

    // bubble moves the load to memory, so a load-use stall never repeats
    singleCycleStall: assert property (
        @(posedge clk) disable iff (!arstN_i)
        stallD |=> !stallD
    ) else $error("coreTop: load-use stall longer than one cycle");

endmodule

//--- tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// operands in assembly order (rd rs rt for R-type and rt rs imm for I-type)
function automatic logic [31:0] rType(input logic [5:0] funct, input int rd, input int rs,
                                      input int rt);
    return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
endfunction

function automatic logic [31:0] iType(input logic [5:0] op, input int rt, input int rs,
                                      input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

// offset in words from the delay slot
function automatic logic [31:0] branchTo(input logic [5:0] op, input int rs, input int rt,
                                         input int offset);
    return {op, 5'(rs), 5'(rt), 16'(offset)};
endfunction

function automatic logic [31:0] jType(input logic [31:0] target);
    return {OP_J, target[27:2]};  // upper pc bits come from the slot address
endfunction

function automatic logic [31:0] jrInstr(input int rs);
    return rType(FUNCT_JR, 0, rs, 0);
endfunction

`endif

//--- tbCore.sv
`timescale 1ns/100ps

module tbCore import cpuPkg::*; ();

    `include "tbProgram.svh"

    localparam int MEM_WORDS = 64;
    localparam int TIMEOUT   = 200;  // cycles per program

    logic                  clk;
    logic                  arstN_i;
    logic [XLEN-1:0]       instAddr;
    logic                  instEn;
    logic [XLEN-1:0]       instr;
    logic                  memEn;
    logic                  memWe;
    logic [XLEN-1:0]       memAddr;
    logic [XLEN-1:0]       memWdata;
    logic [XLEN-1:0]       memRdata;
    logic [XLEN-1:0]       dbgWbPc;
    logic                  dbgWbWen;
    logic [REG_ADDR_W-1:0] dbgWbNum;
    logic [XLEN-1:0]       dbgWbData;
    logic [XLEN-1:0]       imem [MEM_WORDS];
    logic [XLEN-1:0]       dmem [MEM_WORDS];
    logic [XLEN-1:0]       iOffset;

    // expected retirements and stores in program order
    logic [XLEN-1:0]       expPc [$];
    logic [REG_ADDR_W-1:0] expNum [$];
    logic [XLEN-1:0]       expData [$];
    logic [XLEN-1:0]       expStAddr [$];
    logic [XLEN-1:0]       expStData [$];
    int                    expStallCycles;
    int                    progLen;
    int                    testErrors;
    int                    failedTests;
    int                    totalErrors;

    coreTop dut_i (
        .clk, .arstN_i,
        .instAddr_o(instAddr), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memWe_o(memWe), .memAddr_o(memAddr),
        .memWdata_o(memWdata), .memRdata_i(memRdata),
        .dbgWbPc_o(dbgWbPc), .dbgWbWen_o(dbgWbWen), .dbgWbNum_o(dbgWbNum),
        .dbgWbData_o(dbgWbData)
    );

    // both memories answer in the same cycle
    assign iOffset  = instAddr - RESET_PC;
    assign instr    = (iOffset < MEM_WORDS * 4) ? imem[iOffset[7:2]] : '0;
    assign memRdata = dmem[memAddr[7:2]];

    always @(posedge clk) begin
        if (memEn && memWe) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkVal(input string sig, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("[ERROR] %s = %h, expected %h", sig, got, want);
            testErrors++;
        end
    endtask

    task automatic startTest();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;  // all-zero word is sll $0 and writes nothing
            dmem[i] = '0;
        end
        expPc.delete();
        expNum.delete();
        expData.delete();
        expStAddr.delete();
        expStData.delete();
        expStallCycles = 0;
        progLen        = 0;
        testErrors     = 0;
    endtask

    task automatic emit(input logic [XLEN-1:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    // instruction that has to retire writing data into register num
    task automatic emitRet(input logic [XLEN-1:0] word, input int num,
                           input logic [XLEN-1:0] data);
        expPc.push_back(RESET_PC + 32'(progLen * 4));
        expNum.push_back(5'(num));
        expData.push_back(data);
        emit(word);
    endtask

    task automatic resetCore();
        @(posedge clk);
        #1 arstN_i = 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (instEn || memEn || memWe || dbgWbWen) begin
                $display("a fetch, memory or writeback strobe went high during reset");
                testErrors++;
            end
            checkVal("instAddr_o", instAddr, RESET_PC);
            @(posedge clk);
        end
        #1 arstN_i = 1'b1;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        int drain;
        int fetchHeld;
        resetCore();
        cycles    = 0;
        drain     = 0;
        fetchHeld = 0;
        // idle cycles after the last expected pulse catch stray retirements
        while (drain < 8 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (expPc.size() == 0) begin
                drain++;
            end
            if (!instEn) begin
                fetchHeld++;  // one per load-use stall cycle
            end
            if (memEn && memWe) begin
                if (expStAddr.size() == 0) begin
                    $display("unexpected store to address %h", memAddr);
                    testErrors++;
                end else begin
                    checkVal("memAddr_o", memAddr, expStAddr.pop_front());
                    checkVal("memWdata_o", memWdata, expStData.pop_front());
                end
            end
            if (dbgWbWen) begin
                if (expPc.size() == 0) begin
                    $display("extra retirement at pc %h", dbgWbPc);
                    testErrors++;
                end else begin
                    checkVal("dbgWbPc_o", dbgWbPc, expPc.pop_front());
                    checkVal("dbgWbNum_o", 32'(dbgWbNum), 32'(expNum.pop_front()));
                    checkVal("dbgWbData_o", dbgWbData, expData.pop_front());
                end
            end
        end
        if (drain < 8) begin
            $display("timeout in %s, %0d retirements never came", name, expPc.size());
            testErrors++;
        end
        if (expStAddr.size() != 0) begin
            $display("%0d expected stores never reached memory", expStAddr.size());
            testErrors++;
        end
        checkVal("instEn_o low cycles", 32'(fetchHeld), 32'(expStallCycles));
    endtask

    task automatic finishTest(input string name);
        $display("test %s %s (%0d errors)", name, (testErrors == 0) ? "pass" : "FAIL",
                 testErrors);
        totalErrors += testErrors;
        if (testErrors != 0) begin
            failedTests++;
        end
    endtask

    task automatic checkResetState();
        startTest();
        emitRet(iType(OP_ADDIU, 1, 0, 16'h1234), 1, 32'h0000_1234);  // first pc is RESET_PC
        runProgram("reset");
        finishTest("reset");
    endtask

    task automatic aluRandomOps();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [15:0]     imm;
        logic [XLEN-1:0] lt;
        a   = $urandom();
        b   = $urandom();
        imm = 16'($urandom());
        // signed order from the sign bits, magnitudes decide when they agree
        lt  = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, (a < b)};
        startTest();
        emitRet(iType(OP_LUI, 1, 0, a[31:16]), 1, {a[31:16], 16'h0000});
        emitRet(iType(OP_ORI, 1, 1, a[15:0]), 1, a);
        emitRet(iType(OP_LUI, 2, 0, b[31:16]), 2, {b[31:16], 16'h0000});
        emitRet(iType(OP_ORI, 2, 2, b[15:0]), 2, b);
        emitRet(rType(FUNCT_ADDU, 3, 1, 2), 3, a + b);
        emitRet(rType(FUNCT_SUBU, 4, 1, 2), 4, a - b);
        emitRet(rType(FUNCT_AND, 5, 1, 2), 5, a & b);
        emitRet(rType(FUNCT_OR, 6, 1, 2), 6, a | b);
        emitRet(rType(FUNCT_XOR, 7, 1, 2), 7, a ^ b);
        emitRet(rType(FUNCT_SLT, 8, 1, 2), 8, lt);
        emitRet(iType(OP_ADDIU, 9, 1, imm), 9, a + {{16{imm[15]}}, imm});
        emitRet(iType(OP_ANDI, 10, 2, imm), 10, b & {16'h0000, imm});
        runProgram("alu");
        finishTest("alu");
    endtask

    task automatic forwardChains();
        startTest();
        emitRet(iType(OP_ADDIU, 1, 0, 16'd5), 1, 32'd5);
        emitRet(rType(FUNCT_ADDU, 2, 1, 1), 2, 32'd10);  // both from execute
        emitRet(rType(FUNCT_ADDU, 3, 2, 1), 3, 32'd15);  // execute and memory
        emitRet(rType(FUNCT_ADDU, 4, 1, 2), 4, 32'd15);  // writeback and memory
        emitRet(rType(FUNCT_SUBU, 5, 4, 1), 5, 32'd10);  // $1 from the file by now
        runProgram("forward");
        finishTest("forward");
    endtask

    task automatic storeLoadUse();
        startTest();
        emitRet(iType(OP_ADDIU, 1, 0, 16'h0040), 1, 32'h0000_0040);
        emitRet(iType(OP_LUI, 2, 0, 16'hCAFE), 2, 32'hCAFE_0000);
        emitRet(iType(OP_ORI, 2, 2, 16'hBEEF), 2, 32'hCAFE_BEEF);
        emit(iType(OP_SW, 2, 1, 16'h0008));
        expStAddr.push_back(32'h0000_0048);
        expStData.push_back(32'hCAFE_BEEF);
        emitRet(iType(OP_LW, 3, 1, 16'h0008), 3, 32'hCAFE_BEEF);
        emitRet(rType(FUNCT_ADDU, 4, 3, 1), 4, 32'hCAFE_BF2F);  // load-use stall
        expStallCycles = 1;
        runProgram("memory");
        checkVal("dmem[0x48]", dmem[18], 32'hCAFE_BEEF);
        finishTest("memory");
    endtask

    task automatic branchesAndJumps();
        startTest();
        emitRet(iType(OP_ADDIU, 1, 0, 16'd7), 1, 32'd7);
        emitRet(iType(OP_ADDIU, 2, 0, 16'd7), 2, 32'd7);
        emit(branchTo(OP_BEQ, 1, 2, 2));                         // taken to word 5
        emitRet(iType(OP_ADDIU, 3, 0, 16'd1), 3, 32'd1);        // slot
        emit(iType(OP_ADDIU, 8, 0, 16'd99));
        emit(branchTo(OP_BNE, 1, 2, 3));                         // not taken
        emitRet(iType(OP_ADDIU, 4, 0, 16'd2), 4, 32'd2);
        emitRet(iType(OP_ADDIU, 5, 0, 16'd3), 5, 32'd3);
        emit(jType(RESET_PC + 32'd44));                          // to word 11
        emitRet(iType(OP_ADDIU, 6, 0, 16'd4), 6, 32'd4);
        emit(iType(OP_ADDIU, 8, 0, 16'd99));
        emitRet(iType(OP_LUI, 9, 0, 16'hBFC0), 9, 32'hBFC0_0000);
        emitRet(iType(OP_ORI, 9, 9, 16'h0040), 9, 32'hBFC0_0040);
        emit(jrInstr(9));                                        // to word 16
        emitRet(iType(OP_ADDIU, 7, 0, 16'd5), 7, 32'd5);
        emit(iType(OP_ADDIU, 8, 0, 16'd99));
        emit(branchTo(OP_BNE, 1, 0, 2));                         // taken to word 19
        emitRet(iType(OP_ADDIU, 10, 0, 16'd6), 10, 32'd6);
        emit(iType(OP_ADDIU, 8, 0, 16'd99));
        emit(branchTo(OP_BEQ, 1, 0, 2));                         // not taken
        emitRet(iType(OP_ADDIU, 11, 0, 16'd8), 11, 32'd8);
        emitRet(iType(OP_ADDIU, 12, 0, 16'd9), 12, 32'd9);
        runProgram("branch");
        finishTest("branch");
    endtask

    task automatic zeroRegWrites();
        startTest();
        emitRet(iType(OP_ADDIU, 2, 0, 16'd3), 2, 32'd3);
        emit(iType(OP_ADDIU, 0, 2, 16'd5));                     // no pulse
        emitRet(rType(FUNCT_ADDU, 1, 0, 2), 1, 32'd3);
        emit(iType(OP_ORI, 0, 0, 16'hFFFF));
        emitRet(rType(FUNCT_SUBU, 3, 2, 0), 3, 32'd3);
        runProgram("zero");
        finishTest("zero");
    endtask

    initial begin
        arstN_i     = 1'b0;
        failedTests = 0;
        totalErrors = 0;
        void'($urandom(90));
        startTest();  // memories hold no-ops before the first edge
        checkResetState();
        aluRandomOps();
        forwardChains();
        storeLoadUse();
        branchesAndJumps();
        zeroRegWrites();
        $display("tests 6, failed %0d, errors %0d", failedTests, totalErrors);
        if (totalErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- coreTop.f
+incdir+.
cpuPkg.sv
stageReg.sv
regFile.sv
decodeUnit.sv
hazardUnit.sv
execUnit.sv
coreTop.sv
tbCore.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbCore
FILELIST = coreTop.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
